/* source/bias_consts.svh */
// Widths and counts shared by the bias path RTL and its testbench.
// Include wherever a lane width, lane count or replay count is needed.

`ifndef BIAS_CONSTS_SVH
`define BIAS_CONSTS_SVH

// ----------------------------------------
// lane geometry
// ----------------------------------------

`define BIAS_LANE_W 8   // signed bias lane
`define BIAS_LANES  4   // lanes per row word

// one accumulator lane, also the width of a result lane
`define ACC_W 16

// ----------------------------------------
// sequencing
// ----------------------------------------

`define BIAS_REPLAYS 64 // bias beats sent per load

`endif

/* source/bias_pkg.sv */
// Types for the bias path: FSM state, replay direction and stream payloads.
// Modules import it inside their body and use scoped names in port lists.

`default_nettype none

`include "bias_consts.svh"

package bias_pkg;

  // ----------------------------------------
  // lanes
  // ----------------------------------------

  typedef logic signed [`BIAS_LANE_W-1:0] bias_lane_t;
  typedef logic signed [`ACC_W-1:0]       acc_lane_t;

  // ----------------------------------------
  // stream payloads
  // ----------------------------------------

  // lane 0 sits in the low bits
  typedef struct packed {
    bias_lane_t [`BIAS_LANES-1:0] lane;
  } bias_row_t;

  // one load beat, the low row is written to the lower row address
  typedef struct packed {
    bias_row_t hi;
    bias_row_t lo;
  } bias_load_t;

  typedef struct packed {
    acc_lane_t [`BIAS_LANES-1:0] lane;
  } acc_word_t;

  // ----------------------------------------
  // control
  // ----------------------------------------

  typedef enum logic {BIAS_WRITE, BIAS_READ} bias_state_e;

  typedef enum logic {DIR_ROW, DIR_TRANSPOSE} bias_dir_e;

endpackage

`default_nettype wire

/* source/bias_regfile.sv */
// Bias storage: two double-width entries written whole, read back as four rows.
// The read is registered and the output holds while re_i is low.

`timescale 1ns/1ps
`default_nettype none

module bias_regfile (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                we_i,
  input  wire logic                waddr_i,
  input  wire bias_pkg::bias_load_t wdata_i,
  input  wire logic                re_i,
  input  wire logic [1:0]          raddr_i,
  output bias_pkg::bias_row_t      rdata_o
);

  import bias_pkg::*;

  bias_load_t mem_q [2];
  bias_load_t rd_entry;
  bias_row_t  rd_row;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // row address picks the entry with its upper bit and the half with its lower bit
  always_comb begin
    rd_entry = mem_q[raddr_i[1]];
    rd_row   = raddr_i[0] ? rd_entry.hi : rd_entry.lo;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (re_i) begin
      rdata_o <= rd_row; // stays put under stall
    end
  end

endmodule

`default_nettype wire

/* source/bias_input_buffer.sv */
// Bias buffer: takes two load beats into the regfile, then replays the four
// rows as a bias stream, either whole rows or one lane at a time in lane 0.

`timescale 1ns/1ps
`default_nettype none

`include "bias_consts.svh"

module bias_input_buffer (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire bias_pkg::bias_dir_e  dir_i,
  input  wire logic                 load_valid_i,
  output logic                      load_ready_o,
  input  wire bias_pkg::bias_load_t load_data_i,
  output logic                      bias_valid_o,
  input  wire logic                 bias_ready_i,
  output bias_pkg::bias_row_t       bias_row_o
);

  import bias_pkg::*;

  localparam int unsigned REP_W  = $clog2(`BIAS_REPLAYS);
  localparam int unsigned LANE_W = $clog2(`BIAS_LANES);

  bias_state_e       state_d, state_q;
  logic              wr_cnt_d, wr_cnt_q;
  logic [REP_W-1:0]  rep_cnt_d, rep_cnt_q;
  logic              rd_en_d, rd_en_q;
  logic [LANE_W-1:0] lane_q;

  logic      we;
  logic      re;
  logic [1:0] raddr;
  bias_row_t rdata;
  logic      bias_xfer;
  logic      last_xfer;

  assign bias_valid_o = rd_en_q; // registered row is valid
  assign bias_xfer    = bias_valid_o && bias_ready_i;
  assign last_xfer    = bias_xfer && (rep_cnt_q == REP_W'(`BIAS_REPLAYS - 1));

  // ----------------------------------------
  // load and replay FSM
  // ----------------------------------------

  always_comb begin
    state_d      = state_q;
    wr_cnt_d     = wr_cnt_q;
    rep_cnt_d    = rep_cnt_q;
    load_ready_o = 1'b0;
    we           = 1'b0;
    re           = 1'b0;
    raddr        = '0;

    case (state_q)
      BIAS_WRITE: begin
        load_ready_o = 1'b1;
        if (load_valid_i) begin
          we       = 1'b1;
          wr_cnt_d = wr_cnt_q + 1'b1; // wraps back to 0 after the second beat
          if (wr_cnt_q) begin
            state_d = BIAS_READ;
          end
        end
      end
      BIAS_READ: begin
        if (bias_xfer) begin
          rep_cnt_d = rep_cnt_q + 1'b1;
          if (last_xfer) begin
            state_d = BIAS_WRITE;
          end
        end
        // fetch the first row, then one row per transfer, none after the last
        re = (!rd_en_q || bias_xfer) && !last_xfer;
        if (dir_i == DIR_TRANSPOSE) begin
          raddr = rep_cnt_d[LANE_W +: 2];  // new row every 4 beats
        end else begin
          raddr = rep_cnt_d[REP_W-1 -: 2]; // new row every 16 beats
        end
      end
      default: begin
        state_d = BIAS_WRITE;
      end
    endcase
  end

  assign rd_en_d = re || (rd_en_q && !bias_xfer);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= BIAS_WRITE;
      wr_cnt_q  <= 1'b0;
      rep_cnt_q <= '0;
      rd_en_q   <= 1'b0;
      lane_q    <= '0;
    end else begin
      state_q   <= state_d;
      wr_cnt_q  <= wr_cnt_d;
      rep_cnt_q <= rep_cnt_d;
      rd_en_q   <= rd_en_d;
      if (re) begin
        lane_q <= rep_cnt_d[LANE_W-1:0]; // follows the row it belongs to
      end
    end
  end

  bias_regfile bias_regfile_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (we),
    .waddr_i (wr_cnt_q),
    .wdata_i (load_data_i),
    .re_i    (re),
    .raddr_i (raddr),
    .rdata_o (rdata)
  );

  // ----------------------------------------
  // output row
  // ----------------------------------------

  // in transposed mode one lane moves to lane 0 and the rest are zero
  always_comb begin
    bias_row_o = rdata;
    if (dir_i == DIR_TRANSPOSE) begin
      bias_row_o         = '0;
      bias_row_o.lane[0] = rdata.lane[lane_q];
    end
  end

endmodule

`default_nettype wire

/* source/bias_add_stage.sv */
// Add stage: joins the bias and accumulator streams and adds lane by lane
// with signed saturation into one registered result beat.

`timescale 1ns/1ps
`default_nettype none

`include "bias_consts.svh"

module bias_add_stage (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                bias_valid_i,
  output logic                     bias_ready_o,
  input  wire bias_pkg::bias_row_t bias_row_i,
  input  wire logic                acc_valid_i,
  output logic                     acc_ready_o,
  input  wire bias_pkg::acc_word_t acc_data_i,
  output logic                     res_valid_o,
  input  wire logic                res_ready_i,
  output bias_pkg::acc_word_t      res_data_o
);

  import bias_pkg::*;

  logic      out_free;
  logic      join_fire;
  logic      res_valid_q;
  acc_word_t sum;
  acc_word_t res_data_q;

  // adds a sign-extended bias lane and clips to the accumulator range
  function automatic acc_lane_t sat_add(input acc_lane_t a, input bias_lane_t b);
    logic signed [`ACC_W:0] full;
    full = {a[`ACC_W-1], a} + {{(`ACC_W + 1 - `BIAS_LANE_W){b[`BIAS_LANE_W-1]}}, b};
    if (full[`ACC_W] != full[`ACC_W-1]) begin
      // overflow, the carry bit holds the true sign
      return full[`ACC_W] ? {1'b1, {(`ACC_W-1){1'b0}}} : {1'b0, {(`ACC_W-1){1'b1}}};
    end
    return full[`ACC_W-1:0];
  endfunction

  // ----------------------------------------
  // join
  // ----------------------------------------

  assign out_free     = !res_valid_q || res_ready_i; // empty or draining this cycle
  assign bias_ready_o = acc_valid_i && out_free;
  assign acc_ready_o  = bias_valid_i && out_free;
  assign join_fire    = bias_valid_i && acc_valid_i && out_free;

  always_comb begin
    for (int i = 0; i < `BIAS_LANES; i++) begin
      sum.lane[i] = sat_add(acc_data_i.lane[i], bias_row_i.lane[i]);
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (out_free) begin
      res_valid_q <= join_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (join_fire) begin
      res_data_q <= sum;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_data_o  = res_data_q;

endmodule

`default_nettype wire

/* source/bias_unit_top.sv */
// Top of the bias path: the bias buffer feeds the add stage, which meets
// the accumulator stream and drives the result stream.

`timescale 1ns/1ps
`default_nettype none

module bias_unit_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire bias_pkg::bias_dir_e  dir_i,
  input  wire logic                 load_valid_i,
  output logic                      load_ready_o,
  input  wire bias_pkg::bias_load_t load_data_i,
  input  wire logic                 acc_valid_i,
  output logic                      acc_ready_o,
  input  wire bias_pkg::acc_word_t  acc_data_i,
  output logic                      res_valid_o,
  input  wire logic                 res_ready_i,
  output bias_pkg::acc_word_t       res_data_o
);

  import bias_pkg::*;

  logic      bias_valid;
  logic      bias_ready;
  bias_row_t bias_row;

  bias_input_buffer bias_input_buffer_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dir_i        (dir_i),
    .load_valid_i (load_valid_i),
    .load_ready_o (load_ready_o),
    .load_data_i  (load_data_i),
    .bias_valid_o (bias_valid),
    .bias_ready_i (bias_ready),
    .bias_row_o   (bias_row)
  );

  bias_add_stage bias_add_stage_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bias_valid_i (bias_valid),
    .bias_ready_o (bias_ready),
    .bias_row_i   (bias_row),
    .acc_valid_i  (acc_valid_i),
    .acc_ready_o  (acc_ready_o),
    .acc_data_i   (acc_data_i),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_data_o   (res_data_o)
  );

endmodule

`default_nettype wire

/* tb/bias_unit_properties.sv */
// Concurrent checks on the bias path streams, bound into the bias buffer and
// the add stage. Each instance watches one outgoing stream.

`timescale 1ns/1ps
`default_nettype none

module bias_unit_properties #(
  parameter int unsigned DATA_W   = 32,
  parameter bit          HAS_LOAD = 1'b0
) (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire logic                  valid_i,
  input wire logic                  ready_i,
  input wire logic [DATA_W-1:0]     data_i,
  input wire bias_pkg::bias_state_e state_i,
  input wire logic                  load_ready_i
);

  import bias_pkg::*;

  // a stalled beat keeps its valid and its payload
  stream_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i && !ready_i |=> valid_i && $stable(data_i))
    else $error("stream beat changed or dropped while stalled");

  // only the buffer owns a load port
  if (HAS_LOAD) begin : g_load
    // the load port opens only while idle with no bias beat left to send
    load_closed_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_ready_i |-> state_i == BIAS_WRITE && !valid_i)
      else $error("load port ready while the buffer replays or a bias beat is pending");
  end

  valid_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_i)
    else $error("stream valid high during reset");

endmodule

bind bias_input_buffer bias_unit_properties #(
  .DATA_W($bits(bias_pkg::bias_row_t)),
  .HAS_LOAD(1'b1)
) buffer_props_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .valid_i(bias_valid_o), .ready_i(bias_ready_i),
  .data_i(bias_row_o), .state_i(state_q), .load_ready_i(load_ready_o)
);

bind bias_add_stage bias_unit_properties #(
  .DATA_W($bits(bias_pkg::acc_word_t))
) add_props_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .valid_i(res_valid_o), .ready_i(res_ready_i),
  .data_i(res_data_o), .state_i(bias_pkg::BIAS_WRITE), .load_ready_i(1'b0)
);

`default_nettype wire

/* tb/bias_unit_tb.sv */
// Testbench for the bias path: reads tests from a data file, streams bias loads and
// accumulator words into the DUT and checks every result against a reference model.

`timescale 1ns/1ps
`default_nettype none

`include "bias_consts.svh"

module bias_unit_tb;

  import bias_pkg::*;

  localparam string TEST_FILE    = "tb/bias_unit_tests.txt";
  localparam int    RESET_CYCLES = 8;
  localparam int    LOAD_BEATS   = 2;
  localparam int    REPLAYS      = `BIAS_REPLAYS;

  logic       clk_i;
  logic       rst_ni;
  bias_dir_e  dir_i;
  logic       load_valid_i;
  logic       load_ready_o;
  bias_load_t load_data_i;
  logic       acc_valid_i;
  logic       acc_ready_o;
  acc_word_t  acc_data_i;
  logic       res_valid_o;
  logic       res_ready_i;
  acc_word_t  res_data_o;

  // test table as read from the data file
  string      test_name[$];
  bias_dir_e  test_dir[$];
  bias_load_t test_load0[$];
  bias_load_t test_load1[$];
  int         test_stall[$];

  logic [31:0] rng_state   = 32'h9a2cbc07;
  int          errors      = 0;
  int          test_errors = 0;
  int          failed      = 0;
  int          checks      = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;

  bias_unit_top bias_unit_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dir_i        (dir_i),
    .load_valid_i (load_valid_i),
    .load_ready_o (load_ready_o),
    .load_data_i  (load_data_i),
    .acc_valid_i  (acc_valid_i),
    .acc_ready_o  (acc_ready_o),
    .acc_data_i   (acc_data_i),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .res_data_o   (res_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus and reference model
  // ----------------------------------------

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic stall_draw(input int pct);
    return int'(next_random() % 32'd100) < pct;
  endfunction

  // half the lanes sit close to the range limits so that bias can push them over
  function automatic acc_word_t random_acc();
    acc_word_t   w;
    logic [31:0] r;
    for (int i = 0; i < `BIAS_LANES; i++) begin
      r = next_random();
      case (r[31:30])
        2'd0:    w.lane[i] = {9'b011111111, r[6:0]};
        2'd1:    w.lane[i] = {9'b100000000, r[6:0]};
        default: w.lane[i] = r[15:0];
      endcase
    end
    return w;
  endfunction

  // rows 0 to 3 are load0 low, load0 high, load1 low, load1 high
  function automatic bias_row_t expected_bias(input bias_dir_e dir, input bias_load_t l0,
                                              input bias_load_t l1, input int k);
    bias_row_t rows [4];
    bias_row_t src;
    bias_row_t b;
    rows[0] = l0.lo;
    rows[1] = l0.hi;
    rows[2] = l1.lo;
    rows[3] = l1.hi;
    b = '0;
    if (dir == DIR_ROW) begin
      b = rows[k / (REPLAYS / 4)];
    end else begin
      src       = rows[(k / 4) % 4];
      b.lane[0] = src.lane[k % 4];
    end
    return b;
  endfunction

  function automatic acc_lane_t clip_sum(input acc_lane_t a, input bias_lane_t b);
    int s;
    int max_v;
    int min_v;
    max_v = (1 << (`ACC_W - 1)) - 1;
    min_v = -(1 << (`ACC_W - 1));
    s = int'(a) + int'(b);
    if (s > max_v) s = max_v;
    if (s < min_v) s = min_v;
    return acc_lane_t'(s);
  endfunction

  task automatic check_result(input string name, input int idx, input acc_word_t want,
                              input acc_word_t got);
    checks++;
    if (got !== want) begin
      test_errors++;
      $display("ERROR %s result %0d expected %h actual %h", name, idx, want, got);
    end
  endtask

  task automatic read_tests();
    int          fd;
    int          n;
    int          stall;
    string       line;
    string       name;
    string       dir_s;
    logic [63:0] l0;
    logic [63:0] l1;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test file %s", TEST_FILE);
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s %s %h %h %d", name, dir_s, l0, l1, stall);
        if (line.getc(0) != "#" && n == 5) begin
          if ((dir_s != "row" && dir_s != "transpose") || stall < 0 || stall > 90) begin
            $display("test %s has an unknown direction or a stall outside 0 to 90", name);
            errors++;
          end else begin
            test_name.push_back(name);
            test_dir.push_back(dir_s == "row" ? DIR_ROW : DIR_TRANSPOSE);
            test_load0.push_back(l0);
            test_load1.push_back(l1);
            test_stall.push_back(stall);
          end
        end
      end
      $fclose(fd);
    end
    if (test_name.size() == 0) $display("no tests were read from %s", TEST_FILE);
  endtask

  // ----------------------------------------
  // one test: two loads, 64 joined beats
  // ----------------------------------------

  task automatic run_test(input int t);
    acc_word_t acc_q[$];
    acc_word_t want_q[$];
    acc_word_t acc;
    acc_word_t want;
    bias_row_t bias;
    bias_dir_e dir;
    int        loads_sent;
    int        acc_sent;
    int        res_seen;
    logic      load_fire;
    logic      acc_fire;
    dir         = test_dir[t];
    test_errors = 0;
    loads_sent  = 0;
    acc_sent    = 0;
    res_seen    = 0;
    load_fire   = 1'b0;
    acc_fire    = 1'b0;
    for (int k = 0; k < REPLAYS; k++) begin
      acc  = random_acc();
      bias = expected_bias(dir, test_load0[t], test_load1[t], k);
      for (int i = 0; i < `BIAS_LANES; i++) begin
        want.lane[i] = clip_sum(acc.lane[i], bias.lane[i]);
      end
      acc_q.push_back(acc);
      want_q.push_back(want);
    end

    @(negedge clk_i);
    dir_i = dir; // the buffer is idle between tests
    while (res_seen < REPLAYS) begin
      if (load_fire) load_valid_i = 1'b0;
      if (acc_fire) acc_valid_i = 1'b0;
      // a new beat is offered only when no beat is waiting
      if (!load_valid_i && loads_sent < LOAD_BEATS && !stall_draw(test_stall[t])) begin
        load_valid_i = 1'b1;
        load_data_i  = (loads_sent == 0) ? test_load0[t] : test_load1[t];
      end
      if (!acc_valid_i && acc_sent < REPLAYS && !stall_draw(test_stall[t])) begin
        acc_valid_i = 1'b1;
        acc_data_i  = acc_q[acc_sent];
      end
      res_ready_i = !stall_draw(test_stall[t]);
      #10; // ready paths have settled, the handshake below holds at the next rising edge
      if (loads_sent == LOAD_BEATS && res_seen < REPLAYS - 1 && load_ready_o) begin
        $display("load port reopened in test %s before its results were sent", test_name[t]);
        test_errors++;
      end
      load_fire = load_valid_i && load_ready_o;
      acc_fire  = acc_valid_i && acc_ready_o;
      if (load_fire) loads_sent++;
      if (acc_fire) acc_sent++;
      if (res_valid_o && res_ready_i) begin
        check_result(test_name[t], res_seen, want_q[res_seen], res_data_o);
        res_seen++;
      end
      @(negedge clk_i);
    end
    load_valid_i = 1'b0;
    acc_valid_i  = 1'b0;
    res_ready_i  = 1'b0;
    errors += test_errors;
    if (test_errors > 0) failed++;
    $display("test %s (%s): %0d results, %0d errors", test_name[t], dir.name(), res_seen,
             test_errors);
  endtask

  initial begin
    int max_stall;
    rst_ni       = 1'b0;
    dir_i        = DIR_ROW;
    load_valid_i = 1'b0;
    load_data_i  = '0;
    acc_valid_i  = 1'b0;
    acc_data_i   = '0;
    res_ready_i  = 1'b0;
    read_tests();
    max_stall = 0;
    foreach (test_stall[t]) begin
      if (test_stall[t] > max_stall) max_stall = test_stall[t];
    end
    // stalls on both sides of the join slow it by about the square of the stall ratio
    cycle_limit = test_name.size() * REPLAYS *
                  (10000 / ((100 - max_stall) * (100 - max_stall)) + 4) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (test_name[t]) run_test(t);
    $display("%0d tests run, %0d failed, %0d checks, %0d errors", test_name.size(), failed,
             checks, errors);
    if (errors == 0 && test_name.size() > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/bias_unit_tests.txt */
# name  direction (row|transpose)  load0 hex  load1 hex  stall percent
# each load word holds the low row in its lower half, lane 0 in the low byte
row_plain        row        0403020100fffefd 7f10f08081017e55 0
transpose_plain  transpose  1122334455667788 99aabbccddeeff00 0
sat_high_row     row        7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f 0
sat_low_trans    transpose  8080808080808080 8080808080808080 0
sat_mixed_row    row        807f807f7f807f80 7f7f8080807f7f80 0
row_stall        row        0403020100fffefd 7f10f08081017e55 50
transpose_stall  transpose  1122334455667788 99aabbccddeeff00 50
reload_trans     transpose  f1e2d3c4b5a69788 0102030405060708 25
reload_row       row        0badf00d01234567 89abcdef76543210 25

/* filelist.f */
+incdir+source
source/bias_pkg.sv
source/bias_regfile.sv
source/bias_input_buffer.sv
source/bias_add_stage.sv
source/bias_unit_top.sv
tb/bias_unit_properties.sv
tb/bias_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the bias path testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module bias_unit_tb \
  -o bias_unit_sim > build.log 2>&1 \
  && ./obj_dir/bias_unit_sim > "$LOG" 2>&1 \
  || { cat build.log "$LOG" 2>/dev/null; echo "simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "STATUS: FAIL" "$LOG" && { echo "failures reported in $LOG"; exit 1; }
grep -q "STATUS: PASS" "$LOG" || { echo "no pass line found in $LOG"; exit 1; }
echo "simulation passed"
